// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_top -f tb.f -o tb_sim
./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: source/apb_debug_port.sv
// APB debug slave: instruction loading, register readback, run control and busy status
`timescale 1ns/1ps

module apb_debug_port #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  apb_map_pkg::paddr_t           paddr_i,
    input  cpu_isa_pkg::word_t            pwdata_i,
    output cpu_isa_pkg::word_t            prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    output logic                          imem_we_o,
    output logic [$clog2(IMEM_DEPTH)-1:0] imem_waddr_o,
    output cpu_isa_pkg::word_t            imem_wdata_o,
    output logic                          start_o,
    output cpu_isa_pkg::reg_idx_t         dbg_raddr_o,
    input  cpu_isa_pkg::word_t            dbg_rdata_i,
    input  logic                          retired_break_i,
    output logic                          busy_o
);

    localparam int AW = $clog2(IMEM_DEPTH);
    localparam apb_map_pkg::paddr_t IMEM_SPAN_MASK = 12'h3ff;
    localparam apb_map_pkg::paddr_t REGS_SPAN_MASK = 12'h07f;

    logic       access;
    logic       in_imem;
    logic       in_regs;
    logic       is_ctrl;
    logic       is_stat;
    logic       unmapped;
    logic       imem_oob;
    logic [7:0] word_off;

    assign access   = psel_i & penable_i;  // zero wait state, access phase only
    assign word_off = paddr_i[9:2];

    assign in_imem  = (paddr_i & ~IMEM_SPAN_MASK) == apb_map_pkg::IMEM_BASE;
    assign in_regs  = (paddr_i & ~REGS_SPAN_MASK) == apb_map_pkg::REGS_BASE;
    assign is_ctrl  = paddr_i == apb_map_pkg::CTRL_ADDR;
    assign is_stat  = paddr_i == apb_map_pkg::STAT_ADDR;
    assign unmapped = ~(in_imem | in_regs | is_ctrl | is_stat);
    assign imem_oob = int'(word_off) >= IMEM_DEPTH;

    assign pready_o  = access;
    assign pslverr_o = access & (unmapped
                                 | (in_imem & (~pwrite_i | imem_oob))
                                 | (in_regs & pwrite_i)
                                 | (is_stat & pwrite_i));

    assign imem_we_o    = access & pwrite_i & in_imem & ~imem_oob;
    assign imem_waddr_o = word_off[AW-1:0];
    assign imem_wdata_o = pwdata_i;

    assign start_o     = access & pwrite_i & is_ctrl & pwdata_i[apb_map_pkg::CTRL_RUN_BIT];
    assign dbg_raddr_o = paddr_i[6:2];

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            if (in_regs) begin
                prdata_o = dbg_rdata_i;
            end else if (is_stat) begin
                prdata_o[apb_map_pkg::STAT_BUSY_BIT] = busy_o;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_o <= 1'b0;
        end else if (start_o) begin
            busy_o <= 1'b1;
        end else if (retired_break_i) begin
            busy_o <= 1'b0;  // break has left execute
        end
    end

endmodule

// File: source/apb_map_pkg.sv
// APB debug address map: region bases, control and status bit positions
package apb_map_pkg;

    typedef logic [11:0] paddr_t;

    localparam paddr_t IMEM_BASE = 12'h000;  // 256 words
    localparam paddr_t REGS_BASE = 12'h400;  // 32 words
    localparam paddr_t CTRL_ADDR = 12'h800;
    localparam paddr_t STAT_ADDR = 12'h804;

    localparam int CTRL_RUN_BIT  = 0;
    localparam int STAT_BUSY_BIT = 0;

endpackage

// File: source/cpu_isa_pkg.sv
// ISA word and register index types, opcode and funct codes, ALU operation enum
package cpu_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    // SPECIAL funct field, instr[5:0]
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_BREAK = 6'h0d;

    localparam word_t NOP_WORD = 32'h0000_0000;  // sll r0,r0,0

endpackage

// File: source/decode_stage.sv
// instruction decode, operand bypass, break drain FSM and decode/execute register
`timescale 1ns/1ps

module decode_stage (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     start_i,
    input  logic                     if_valid_i,
    input  cpu_isa_pkg::word_t       if_instr_i,
    output cpu_isa_pkg::reg_idx_t    rf_raddr_a_o,
    output cpu_isa_pkg::reg_idx_t    rf_raddr_b_o,
    input  cpu_isa_pkg::word_t       rf_rdata_a_i,
    input  cpu_isa_pkg::word_t       rf_rdata_b_i,
    input  logic                     ex_fwd_wr_i,
    input  cpu_isa_pkg::reg_idx_t    ex_fwd_rd_i,
    input  cpu_isa_pkg::word_t       ex_fwd_data_i,
    input  logic                     wb_wr_i,
    input  cpu_isa_pkg::reg_idx_t    wb_rd_i,
    input  cpu_isa_pkg::word_t       wb_data_i,
    output logic                     halt_o,
    output logic                     id_valid_o,
    output cpu_isa_pkg::alu_op_e     id_alu_op_o,
    output cpu_isa_pkg::word_t       id_opa_o,
    output cpu_isa_pkg::word_t       id_opb_o,
    output cpu_isa_pkg::reg_idx_t    id_rd_o,
    output logic                     id_wr_en_o,
    output logic                     id_break_o
);

    typedef enum logic {
        DEC_RUN,
        DEC_DRAIN
    } dec_state_e;

    dec_state_e            state;
    logic [5:0]            opcode;
    logic [5:0]            funct;
    cpu_isa_pkg::reg_idx_t rs;
    cpu_isa_pkg::reg_idx_t rt;
    cpu_isa_pkg::reg_idx_t dest;
    logic [15:0]           imm;
    cpu_isa_pkg::alu_op_e  alu_op;
    logic                  wr_en;
    logic                  is_break;
    logic                  use_imm;
    logic                  sext_imm;
    logic                  accept;
    cpu_isa_pkg::word_t    imm_ext;
    cpu_isa_pkg::word_t    opa;
    cpu_isa_pkg::word_t    opb;

    // youngest producer wins and r0 is never forwarded
    function automatic cpu_isa_pkg::word_t pick_operand(
        input cpu_isa_pkg::reg_idx_t idx,
        input cpu_isa_pkg::word_t    rf_data
    );
        if (idx == '0) begin
            return '0;
        end else if (ex_fwd_wr_i && ex_fwd_rd_i == idx) begin
            return ex_fwd_data_i;
        end else if (wb_wr_i && wb_rd_i == idx) begin
            return wb_data_i;
        end
        return rf_data;
    endfunction

    assign opcode = if_instr_i[31:26];
    assign rs     = if_instr_i[25:21];
    assign rt     = if_instr_i[20:16];
    assign funct  = if_instr_i[5:0];
    assign imm    = if_instr_i[15:0];

    assign rf_raddr_a_o = rs;
    assign rf_raddr_b_o = rt;

    always_comb begin
        alu_op   = cpu_isa_pkg::ALU_ADD;
        wr_en    = 1'b0;
        is_break = 1'b0;
        use_imm  = 1'b0;
        sext_imm = 1'b0;
        case (opcode)
            cpu_isa_pkg::OPC_SPECIAL: begin
                wr_en = 1'b1;
                case (funct)
                    cpu_isa_pkg::FN_ADDU: alu_op = cpu_isa_pkg::ALU_ADD;
                    cpu_isa_pkg::FN_SUBU: alu_op = cpu_isa_pkg::ALU_SUB;
                    cpu_isa_pkg::FN_AND:  alu_op = cpu_isa_pkg::ALU_AND;
                    cpu_isa_pkg::FN_OR:   alu_op = cpu_isa_pkg::ALU_OR;
                    cpu_isa_pkg::FN_XOR:  alu_op = cpu_isa_pkg::ALU_XOR;
                    cpu_isa_pkg::FN_SLT:  alu_op = cpu_isa_pkg::ALU_SLT;
                    cpu_isa_pkg::FN_BREAK: begin
                        wr_en    = 1'b0;
                        is_break = 1'b1;
                    end
                    default: wr_en = 1'b0;  // nop and unsupported funct
                endcase
            end
            cpu_isa_pkg::OPC_ADDIU: begin
                wr_en    = 1'b1;
                use_imm  = 1'b1;
                sext_imm = 1'b1;
            end
            cpu_isa_pkg::OPC_ORI: begin
                alu_op  = cpu_isa_pkg::ALU_OR;
                wr_en   = 1'b1;
                use_imm = 1'b1;
            end
            cpu_isa_pkg::OPC_LUI: begin
                alu_op  = cpu_isa_pkg::ALU_LUI;
                wr_en   = 1'b1;
                use_imm = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign imm_ext = sext_imm ? {{16{imm[15]}}, imm} : {16'h0000, imm};
    assign dest    = use_imm ? rt : if_instr_i[15:11];

    always_comb begin
        opa = pick_operand(rs, rf_rdata_a_i);
        opb = use_imm ? imm_ext : pick_operand(rt, rf_rdata_b_i);
    end

    assign accept = (state == DEC_RUN) & if_valid_i;
    assign halt_o = accept & is_break;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= DEC_RUN;
        end else if (start_i) begin
            state <= DEC_RUN;
        end else if (halt_o) begin
            state <= DEC_DRAIN;  // squash until next start
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid_o <= 1'b0;
            id_wr_en_o <= 1'b0;
            id_break_o <= 1'b0;
        end else begin
            id_valid_o <= accept;
            id_wr_en_o <= accept & wr_en;
            id_break_o <= accept & is_break;
        end
    end

    always_ff @(posedge clk) begin
        id_alu_op_o <= alu_op;
        id_opa_o    <= opa;
        id_opb_o    <= opb;
        id_rd_o     <= dest;
    end

endmodule

// File: source/execute_stage.sv
// execute stage: ALU, bypass outputs and execute/writeback register
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  id_valid_i,
    input  cpu_isa_pkg::alu_op_e  id_alu_op_i,
    input  cpu_isa_pkg::word_t    id_opa_i,
    input  cpu_isa_pkg::word_t    id_opb_i,
    input  cpu_isa_pkg::reg_idx_t id_rd_i,
    input  logic                  id_wr_en_i,
    input  logic                  id_break_i,
    output logic                  ex_fwd_wr_o,
    output cpu_isa_pkg::reg_idx_t ex_fwd_rd_o,
    output cpu_isa_pkg::word_t    ex_fwd_data_o,
    output logic                  wb_wr_o,
    output cpu_isa_pkg::reg_idx_t wb_rd_o,
    output cpu_isa_pkg::word_t    wb_data_o,
    output logic                  retired_break_o
);

    cpu_isa_pkg::word_t alu_result;

    always_comb begin
        case (id_alu_op_i)
            cpu_isa_pkg::ALU_ADD: alu_result = id_opa_i + id_opb_i;
            cpu_isa_pkg::ALU_SUB: alu_result = id_opa_i - id_opb_i;
            cpu_isa_pkg::ALU_AND: alu_result = id_opa_i & id_opb_i;
            cpu_isa_pkg::ALU_OR:  alu_result = id_opa_i | id_opb_i;
            cpu_isa_pkg::ALU_XOR: alu_result = id_opa_i ^ id_opb_i;
            cpu_isa_pkg::ALU_SLT: alu_result = {31'b0, $signed(id_opa_i) < $signed(id_opb_i)};
            cpu_isa_pkg::ALU_LUI: alu_result = {id_opb_i[15:0], 16'h0000};
            default:              alu_result = '0;
        endcase
    end

    // result seen by decode in the same cycle
    assign ex_fwd_wr_o   = id_valid_i & id_wr_en_i;
    assign ex_fwd_rd_o   = id_rd_i;
    assign ex_fwd_data_o = alu_result;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_wr_o         <= 1'b0;
            retired_break_o <= 1'b0;
        end else begin
            wb_wr_o         <= ex_fwd_wr_o;
            retired_break_o <= id_valid_i & id_break_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= id_rd_i;
        wb_data_o <= alu_result;
    end

endmodule

// File: source/fetch_stage.sv
// fetch stage: instruction memory, program counter and fetch/decode register
`timescale 1ns/1ps

module fetch_stage #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          start_i,
    input  logic                          halt_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_waddr_i,
    input  cpu_isa_pkg::word_t            imem_wdata_i,
    output logic                          if_valid_o,
    output cpu_isa_pkg::word_t            if_instr_o
);

    localparam int AW = $clog2(IMEM_DEPTH);

    cpu_isa_pkg::word_t imem [IMEM_DEPTH];
    logic [AW-1:0]      pc;
    logic               running;
    logic               fetch_en;

    assign fetch_en = running & ~halt_i;

    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_waddr_i] <= imem_wdata_i;  // host load over APB
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            running    <= 1'b0;
            pc         <= '0;
            if_valid_o <= 1'b0;
        end else if (start_i) begin
            running    <= 1'b1;
            pc         <= '0;
            if_valid_o <= 1'b0;
        end else begin
            if (halt_i) begin
                running <= 1'b0;
            end
            if (fetch_en) begin
                pc <= pc + AW'(1);  // wraps at IMEM_DEPTH
            end
            if_valid_o <= fetch_en;
        end
    end

    always_ff @(posedge clk) begin
        if_instr_o <= fetch_en ? imem[pc] : cpu_isa_pkg::NOP_WORD;
    end

endmodule

// File: source/mips_core_top.sv
// top level: APB debug port and four-stage pipeline with register file
`timescale 1ns/1ps

module mips_core_top #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  apb_map_pkg::paddr_t paddr_i,
    input  cpu_isa_pkg::word_t  pwdata_i,
    output cpu_isa_pkg::word_t  prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    output logic                busy_o
);

    localparam int AW = $clog2(IMEM_DEPTH);

    logic                  imem_we, start, retired_break, halt, if_valid;
    logic [AW-1:0]         imem_waddr;
    cpu_isa_pkg::word_t    imem_wdata, dbg_rdata, if_instr;
    cpu_isa_pkg::reg_idx_t dbg_raddr, rf_raddr_a, rf_raddr_b;
    cpu_isa_pkg::word_t    rf_rdata_a, rf_rdata_b;

    logic                  id_valid, id_wr_en, id_break;
    cpu_isa_pkg::alu_op_e  id_alu_op;
    cpu_isa_pkg::word_t    id_opa, id_opb;
    cpu_isa_pkg::reg_idx_t id_rd;

    logic                  ex_fwd_wr, wb_wr;
    cpu_isa_pkg::reg_idx_t ex_fwd_rd, wb_rd;
    cpu_isa_pkg::word_t    ex_fwd_data, wb_data;

    apb_debug_port #(.IMEM_DEPTH(IMEM_DEPTH)) i_apb (
        .clk(clk), .resetn(resetn),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .imem_we_o(imem_we), .imem_waddr_o(imem_waddr), .imem_wdata_o(imem_wdata),
        .start_o(start), .dbg_raddr_o(dbg_raddr), .dbg_rdata_i(dbg_rdata),
        .retired_break_i(retired_break), .busy_o(busy_o)
    );

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) i_fetch (
        .clk(clk), .resetn(resetn), .start_i(start), .halt_i(halt),
        .imem_we_i(imem_we), .imem_waddr_i(imem_waddr), .imem_wdata_i(imem_wdata),
        .if_valid_o(if_valid), .if_instr_o(if_instr)
    );

    decode_stage i_decode (
        .clk(clk), .resetn(resetn), .start_i(start),
        .if_valid_i(if_valid), .if_instr_i(if_instr),
        .rf_raddr_a_o(rf_raddr_a), .rf_raddr_b_o(rf_raddr_b),
        .rf_rdata_a_i(rf_rdata_a), .rf_rdata_b_i(rf_rdata_b),
        .ex_fwd_wr_i(ex_fwd_wr), .ex_fwd_rd_i(ex_fwd_rd), .ex_fwd_data_i(ex_fwd_data),
        .wb_wr_i(wb_wr), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .halt_o(halt), .id_valid_o(id_valid), .id_alu_op_o(id_alu_op),
        .id_opa_o(id_opa), .id_opb_o(id_opb), .id_rd_o(id_rd),
        .id_wr_en_o(id_wr_en), .id_break_o(id_break)
    );

    register_file i_regs (
        .clk(clk), .resetn(resetn),
        .raddr_a_i(rf_raddr_a), .raddr_b_i(rf_raddr_b), .dbg_raddr_i(dbg_raddr),
        .rdata_a_o(rf_rdata_a), .rdata_b_o(rf_rdata_b), .dbg_rdata_o(dbg_rdata),
        .we_i(wb_wr), .waddr_i(wb_rd), .wdata_i(wb_data)
    );

    execute_stage i_execute (
        .clk(clk), .resetn(resetn),
        .id_valid_i(id_valid), .id_alu_op_i(id_alu_op),
        .id_opa_i(id_opa), .id_opb_i(id_opb), .id_rd_i(id_rd),
        .id_wr_en_i(id_wr_en), .id_break_i(id_break),
        .ex_fwd_wr_o(ex_fwd_wr), .ex_fwd_rd_o(ex_fwd_rd), .ex_fwd_data_o(ex_fwd_data),
        .wb_wr_o(wb_wr), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .retired_break_o(retired_break)
    );

endmodule

// File: source/register_file.sv
// 32-entry register file: two operand read ports, debug read port, one write port
`timescale 1ns/1ps

module register_file (
    input  logic                  clk,
    input  logic                  resetn,
    input  cpu_isa_pkg::reg_idx_t raddr_a_i,
    input  cpu_isa_pkg::reg_idx_t raddr_b_i,
    input  cpu_isa_pkg::reg_idx_t dbg_raddr_i,
    output cpu_isa_pkg::word_t    rdata_a_o,
    output cpu_isa_pkg::word_t    rdata_b_o,
    output cpu_isa_pkg::word_t    dbg_rdata_o,
    input  logic                  we_i,
    input  cpu_isa_pkg::reg_idx_t waddr_i,
    input  cpu_isa_pkg::word_t    wdata_i
);

    cpu_isa_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;  // r0 stays zero
        end
    end

    assign rdata_a_o   = regs[raddr_a_i];
    assign rdata_b_o   = regs[raddr_b_i];
    assign dbg_rdata_o = regs[dbg_raddr_i];

endmodule

// File: tb.f
+incdir+verification
source/cpu_isa_pkg.sv
source/apb_map_pkg.sv
source/apb_debug_port.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/mips_core_top.sv
verification/core_assertions.sv
verification/tb_top.sv

// File: verification/core_assertions.sv
// concurrent checks on the APB response and the register-zero debug read
`timescale 1ns/1ps

module core_assertions (
    input logic                  clk,
    input logic                  resetn,
    input logic                  psel_i,
    input logic                  penable_i,
    input logic                  pready_i,
    input logic                  pslverr_i,
    input cpu_isa_pkg::reg_idx_t dbg_raddr_i,
    input cpu_isa_pkg::word_t    dbg_rdata_i
);

    a_pready_in_access: assert property (@(posedge clk) disable iff (!resetn)
        (psel_i && penable_i) |-> pready_i)
        else $error("pready low during an APB access phase");

    a_no_slverr_outside_access: assert property (@(posedge clk) disable iff (!resetn)
        !(psel_i && penable_i) |-> !pslverr_i)
        else $error("pslverr high outside an APB access phase");

    a_r0_reads_zero: assert property (@(posedge clk) disable iff (!resetn)
        (dbg_raddr_i == 5'd0) |-> (dbg_rdata_i == 32'd0))
        else $error("debug read of r0 returned a nonzero value");

endmodule

bind apb_debug_port core_assertions i_core_assertions (
    .clk(clk), .resetn(resetn),
    .psel_i(psel_i), .penable_i(penable_i),
    .pready_i(pready_o), .pslverr_i(pslverr_o),
    .dbg_raddr_i(dbg_raddr_o), .dbg_rdata_i(dbg_rdata_i)
);

// File: verification/tb_model.svh
// random program generator and register reference model, included by tb_top
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int WINDOW     = 8;  // registers touched by one program
localparam int TAIL_WORDS = 3;  // dead words placed after break

integer             seed = 32'hded346eb;
cpu_isa_pkg::word_t prog [IMEM_DEPTH];
int                 prog_len;
cpu_isa_pkg::word_t exp_regs [32];

function automatic int rand_below(input int n);
    logic [31:0] v;
    v = $random(seed);
    return int'({1'b0, v[30:0]}) % n;
endfunction

function automatic cpu_isa_pkg::reg_idx_t pick_reg(input int base);
    if (rand_below(8) == 0) begin
        return 5'd0;  // r0 as source or sink now and then
    end
    return 5'(base + rand_below(WINDOW));
endfunction

// kind: 0 addu, 1 subu, 2 and, 3 or, 4 xor, 5 slt, 6 addiu, 7 ori, 8 lui
function automatic cpu_isa_pkg::word_t encode_instr(
    input int                    kind,
    input cpu_isa_pkg::reg_idx_t rs,
    input cpu_isa_pkg::reg_idx_t rt,
    input cpu_isa_pkg::reg_idx_t rd,
    input logic [15:0]           imm
);
    logic [5:0] fn;
    case (kind)
        0: fn = cpu_isa_pkg::FN_ADDU;
        1: fn = cpu_isa_pkg::FN_SUBU;
        2: fn = cpu_isa_pkg::FN_AND;
        3: fn = cpu_isa_pkg::FN_OR;
        4: fn = cpu_isa_pkg::FN_XOR;
        5: fn = cpu_isa_pkg::FN_SLT;
        6: return {cpu_isa_pkg::OPC_ADDIU, rs, rd, imm};  // i-type target sits in rt field
        7: return {cpu_isa_pkg::OPC_ORI, rs, rd, imm};
        default: return {cpu_isa_pkg::OPC_LUI, 5'd0, rd, imm};
    endcase
    return {cpu_isa_pkg::OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

function automatic cpu_isa_pkg::word_t alu_model(
    input int                 kind,
    input cpu_isa_pkg::word_t a,
    input cpu_isa_pkg::word_t b,
    input logic [15:0]        imm
);
    case (kind)
        0: return a + b;
        1: return a - b;
        2: return a & b;
        3: return a | b;
        4: return a ^ b;
        5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        6: return a + {{16{imm[15]}}, imm};
        7: return a | {16'h0000, imm};
        default: return {imm, 16'h0000};
    endcase
endfunction

task automatic build_program(input int body_len);
    int                    base;
    int                    kind;
    cpu_isa_pkg::reg_idx_t rs;
    cpu_isa_pkg::reg_idx_t rt;
    cpu_isa_pkg::reg_idx_t rd;
    logic [15:0]           imm;
    base     = 1 + rand_below(32 - WINDOW);
    rd       = 5'(base);
    prog_len = 0;
    for (int i = 0; i < WINDOW; i++) begin
        prog[prog_len] = encode_instr(0, 5'd0, 5'd0, 5'(base + i), 16'h0000);  // addu rX,r0,r0
        exp_regs[base + i] = '0;
        prog_len++;
    end
    for (int i = 0; i < body_len; i++) begin
        rs   = (rand_below(2) == 0) ? rd : pick_reg(base);  // lean on the previous result
        rt   = pick_reg(base);
        rd   = pick_reg(base);
        kind = rand_below(9);
        imm  = 16'($random(seed));
        prog[prog_len] = encode_instr(kind, rs, rt, rd, imm);
        if (rd != 5'd0) begin
            exp_regs[rd] = alu_model(kind, exp_regs[rs], exp_regs[rt], imm);
        end
        prog_len++;
    end
    prog[prog_len] = {cpu_isa_pkg::OPC_SPECIAL, 20'h00000, cpu_isa_pkg::FN_BREAK};
    prog_len++;
    for (int i = 0; i < TAIL_WORDS; i++) begin
        // never retired, so the model skips them
        prog[prog_len] = encode_instr(6, 5'd0, 5'd0, 5'(base + rand_below(WINDOW)),
                                      16'($random(seed)));
        prog_len++;
    end
endtask

`endif

// File: verification/tb_top.sv
// clock and reset, APB access tasks, program runs, checks and watchdog of the core testbench
`timescale 1ns/1ps

module tb_top;

    localparam int IMEM_DEPTH      = 64;
    localparam int NUM_PROGS       = 8;
    localparam int HALF_PERIOD     = 10;
    localparam int WATCHDOG_CYCLES = (NUM_PROGS + 2) * (IMEM_DEPTH + 64) * 4;
    localparam int POLL_LIMIT      = 4 * IMEM_DEPTH;

    logic                clk;
    logic                resetn;
    logic                psel;
    logic                penable;
    logic                pwrite;
    apb_map_pkg::paddr_t paddr;
    cpu_isa_pkg::word_t  pwdata;
    cpu_isa_pkg::word_t  prdata;
    logic                pready;
    logic                pslverr;
    logic                busy;
    int                  err_count;
    int                  check_count;

    `include "tb_model.svh"

    mips_core_top #(.IMEM_DEPTH(IMEM_DEPTH)) i_dut (
        .clk(clk), .resetn(resetn),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
        .busy_o(busy)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run hung, watchdog expired after %0d clock cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_value(input string name, input cpu_isa_pkg::word_t expected,
                               input cpu_isa_pkg::word_t actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // setup cycle then access phase sampled at the falling edge
    task automatic bus_transfer(input logic write, input apb_map_pkg::paddr_t addr,
                                input cpu_isa_pkg::word_t wdata,
                                output cpu_isa_pkg::word_t rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waits < 8) begin
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            err_count++;
            $display("APB access to %h never saw pready", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_word(input apb_map_pkg::paddr_t addr, input cpu_isa_pkg::word_t data);
        cpu_isa_pkg::word_t rdata;
        logic               err;
        bus_transfer(1'b1, addr, data, rdata, err);
        check_value($sformatf("pslverr_o@%h", addr), 32'd0, 32'(err));
    endtask

    task automatic read_word(input apb_map_pkg::paddr_t addr, output cpu_isa_pkg::word_t data);
        logic err;
        bus_transfer(1'b0, addr, 32'd0, data, err);
        check_value($sformatf("pslverr_o@%h", addr), 32'd0, 32'(err));
    endtask

    task automatic expect_slverr(input logic write, input apb_map_pkg::paddr_t addr);
        cpu_isa_pkg::word_t rdata;
        logic               err;
        bus_transfer(write, addr, 32'h3c1fdead, rdata, err);  // lui r31,0xdead
        check_value($sformatf("pslverr_o@%h", addr), 32'd1, 32'(err));
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            write_word(apb_map_pkg::IMEM_BASE + 12'(4 * i), prog[i]);
        end
    endtask

    task automatic run_to_break();
        cpu_isa_pkg::word_t stat;
        int                 polls;
        write_word(apb_map_pkg::CTRL_ADDR, 32'd1 << apb_map_pkg::CTRL_RUN_BIT);
        @(negedge clk);
        check_value("busy_o", 32'd1, 32'(busy));  // start sets busy
        polls = 0;
        stat  = 32'd1 << apb_map_pkg::STAT_BUSY_BIT;
        while (stat[apb_map_pkg::STAT_BUSY_BIT] && polls < POLL_LIMIT) begin
            read_word(apb_map_pkg::STAT_ADDR, stat);
            polls++;
        end
        if (stat[apb_map_pkg::STAT_BUSY_BIT]) begin
            err_count++;
            $display("core still busy after %0d status polls, BREAK never retired", polls);
        end
        @(negedge clk);
        check_value("busy_o", 32'd0, 32'(busy));
    endtask

    task automatic compare_regs();
        cpu_isa_pkg::word_t val;
        for (int r = 0; r < 32; r++) begin
            read_word(apb_map_pkg::REGS_BASE + 12'(4 * r), val);
            check_value($sformatf("r%0d", r), exp_regs[r], val);
        end
    endtask

    initial begin
        cpu_isa_pkg::word_t ctrl_val;
        err_count   = 0;
        check_count = 0;
        resetn      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        for (int r = 0; r < 32; r++) begin
            exp_regs[r] = '0;
        end
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_value("busy_o", 32'd0, 32'(busy));
        compare_regs();

        for (int p = 0; p < NUM_PROGS; p++) begin
            build_program(12 + rand_below(41));  // 20 to 60 words before break
            load_program();
            run_to_break();
            compare_regs();
        end

        // illegal accesses leave all state alone
        expect_slverr(1'b1, apb_map_pkg::IMEM_BASE + 12'(4 * IMEM_DEPTH));
        expect_slverr(1'b0, apb_map_pkg::IMEM_BASE + 12'h010);
        expect_slverr(1'b1, apb_map_pkg::STAT_ADDR);
        expect_slverr(1'b1, apb_map_pkg::REGS_BASE + 12'h07c);
        expect_slverr(1'b0, 12'hc00);
        expect_slverr(1'b1, 12'h808);
        read_word(apb_map_pkg::CTRL_ADDR, ctrl_val);
        check_value("prdata_o@ctrl", 32'd0, ctrl_val);
        compare_regs();

        // rerun of the program already in memory
        run_to_break();
        compare_regs();

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
